//--- bench/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
   output logic clk,
   output logic arst_n
   );

   initial
   begin
      clk = 1'b0;
      forever
         #2 clk = ~clk;                               // 4 ns period
   end

   initial
   begin
      arst_n = 1'b0;
      repeat (8)
         @(posedge clk);
      arst_n <= 1'b1;
   end

endmodule

`default_nettype wire

//--- bench/tb_chess_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_chess_ctrl
   import vchess_pkg::*;
   ();

   localparam int CLK_NS = 4;
   localparam int TESTS = 6;
   localparam int TEST_CYCLES = 2000;
   localparam int WATCHDOG_NS = TESTS * TEST_CYCLES * CLK_NS + 20000;

   logic clk;
   logic arst_n;
   axi_addr_t axi_awaddr;
   logic axi_awvalid;
   logic axi_awready;
   axi_data_t axi_wdata;
   logic [3:0] axi_wstrb;
   logic axi_wvalid;
   logic axi_wready;
   logic [1:0] axi_bresp;
   logic axi_bvalid;
   logic axi_bready;
   axi_addr_t axi_araddr;
   logic axi_arvalid;
   logic axi_arready;
   axi_data_t axi_rdata;
   logic [1:0] axi_rresp;
   logic axi_rvalid;
   logic axi_rready;

   int cycle_count = 0;
   logic [31:0] lfsr_state;
   board_t board;
   move_cnt_t exp_count;
   move_t exp_moves [MAX_MOVES];
   sq_map_t exp_wmap;
   sq_map_t exp_bmap;
   logic exp_wcheck;
   logic exp_bcheck;

   clk_gen clk_gen_i (
      .clk    (clk),
      .arst_n (arst_n)
   );

   chess_ctrl_top dut_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .axi_awaddr  (axi_awaddr),
      .axi_awvalid (axi_awvalid),
      .axi_awready (axi_awready),
      .axi_wdata   (axi_wdata),
      .axi_wstrb   (axi_wstrb),
      .axi_wvalid  (axi_wvalid),
      .axi_wready  (axi_wready),
      .axi_bresp   (axi_bresp),
      .axi_bvalid  (axi_bvalid),
      .axi_bready  (axi_bready),
      .axi_araddr  (axi_araddr),
      .axi_arvalid (axi_arvalid),
      .axi_arready (axi_arready),
      .axi_rdata   (axi_rdata),
      .axi_rresp   (axi_rresp),
      .axi_rvalid  (axi_rvalid),
      .axi_rready  (axi_rready)
   );

   always @(posedge clk)
      cycle_count <= cycle_count + 1;

   task automatic stop_on_error();
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check_word(input string name, input axi_data_t got, input axi_data_t exp);
      if (got !== exp)
      begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_move(input string name, input move_t got, input move_t exp);
      if (got !== exp)
      begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_map(input string name, input sq_map_t got, input sq_map_t exp);
      if (got !== exp)
      begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_count(input string name, input move_cnt_t got, input move_cnt_t exp);
      if (got !== exp)
      begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_timeout(input int start, input int limit, input string what);
      if (cycle_count - start > limit)
      begin
         $display("Timed out after %0d cycles waiting for %s", limit, what);
         stop_on_error();
      end
   endtask

   task automatic axi_write(input reg_addr_t reg_idx, input axi_data_t data, input int stall);
      int start;
      int held;
      logic aw_done;
      logic w_done;
      logic b_done;
      start = cycle_count;
      held = 0;
      aw_done = 1'b0;
      w_done = 1'b0;
      b_done = 1'b0;
      @(posedge clk);
      axi_awaddr <= {reg_idx, 2'b00};
      axi_awvalid <= 1'b1;
      axi_wdata <= data;
      axi_wstrb <= 4'hf;
      axi_wvalid <= 1'b1;
      axi_bready <= (stall == 0);
      while (!(aw_done && w_done))
      begin
         @(posedge clk);
         if (axi_awvalid && axi_awready)
         begin
            aw_done = 1'b1;
            axi_awvalid <= 1'b0;
         end
         if (axi_wvalid && axi_wready)
         begin
            w_done = 1'b1;
            axi_wvalid <= 1'b0;
         end
         check_timeout(start, 100, "write address and data");
      end
      while (!b_done)
      begin
         @(posedge clk);
         if (axi_bvalid && axi_bready)
         begin
            b_done = 1'b1;
            check_word("bresp", 32'(axi_bresp), 32'(RESP_OKAY));
         end
         else if (axi_bvalid)
         begin
            if (axi_awready)
            begin
               $display("Write address accepted while the response was stalled");
               stop_on_error();
            end
            held++;
            if (held > stall)
               axi_bready <= 1'b1;
         end
         else if (held > 0)
         begin
            $display("Write response withdrawn before bready");
            stop_on_error();
         end
         check_timeout(start, 100, "write response");
      end
      axi_bready <= 1'b0;
   endtask

   task automatic axi_read(input reg_addr_t reg_idx, output axi_data_t data);
      int start;
      start = cycle_count;
      @(posedge clk);
      axi_araddr <= {reg_idx, 2'b00};
      axi_arvalid <= 1'b1;
      axi_rready <= 1'b1;
      @(posedge clk);
      if (!axi_arready)
      begin
         $display("Read address not accepted");
         stop_on_error();
      end
      axi_arvalid <= 1'b0;
      do
      begin
         @(posedge clk);
         check_timeout(start, 100, "read data");
      end
      while (!(axi_rvalid && axi_rready));
      data = axi_rdata;
      check_word("rresp", 32'(axi_rresp), 32'(RESP_OKAY));
      axi_rready <= 1'b0;
   endtask

   task automatic read_map(input reg_addr_t lo_reg, output sq_map_t map);
      axi_data_t lo;
      axi_data_t hi;
      axi_read(lo_reg, lo);
      axi_read(reg_addr_t'(lo_reg + 1), hi);
      map = {hi, lo};
   endtask

   // Polls the status register until the given bit is set
   task automatic wait_status(input int bit_pos, input string what);
      axi_data_t status;
      int start;
      start = cycle_count;
      axi_read(REG_CTRL, status);
      while (!status[bit_pos])
      begin
         check_timeout(start, TEST_CYCLES, what);
         axi_read(REG_CTRL, status);
      end
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] draw_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = {lfsr_state[30:0],
                       lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic piece_t piece(input logic black, input logic [2:0] kind);
      return {black, kind};
   endfunction

   task automatic random_board(output logic white);
      piece_t code;
      for (int s = 0; s < 64; s++)
      begin
         code = '0;
         if (draw_bits(2) == 0)                       // Occupied one time in four
            do
               code = piece_t'(draw_bits(4));
            while (code[2:0] == KIND_EMPTY || code[2:0] == 3'd7);
         board[4*s +: 4] = code;
      end
      white = draw_bits(1);
   endtask

   task automatic build_model(input logic white);
      piece_t p;
      piece_t tp;
      int row;
      int col;
      int t;
      int wk;
      int bk;
      logic is_knight;
      exp_count = '0;
      exp_wmap = '0;
      exp_bmap = '0;
      wk = -1;
      bk = -1;
      for (int s = 0; s < 64; s++)
      begin
         p = board[4*s +: 4];
         is_knight = (p[2:0] == KIND_KNIGHT);
         if (p[2:0] == KIND_KING && p[COLOUR_BIT])
            bk = s;
         if (p[2:0] == KIND_KING && !p[COLOUR_BIT])
            wk = s;
         if (is_knight || p[2:0] == KIND_KING)
            for (int d = 0; d < 8; d++)
            begin
               row = s / 8 + (is_knight ? int'(KNIGHT_DR[d]) : int'(KING_DR[d]));
               col = s % 8 + (is_knight ? int'(KNIGHT_DC[d]) : int'(KING_DC[d]));
               if (row >= 0 && row < 8 && col >= 0 && col < 8)
               begin
                  t = row * 8 + col;
                  tp = board[4*t +: 4];
                  if (p[COLOUR_BIT])
                     exp_bmap[t] = 1'b1;
                  else
                     exp_wmap[t] = 1'b1;
                  if (p[COLOUR_BIT] != white && exp_count < MAX_MOVES &&
                      (tp[2:0] == KIND_EMPTY || tp[COLOUR_BIT] != p[COLOUR_BIT]))
                  begin
                     exp_moves[exp_count[5:0]] = {tp[2:0] != KIND_EMPTY,
                                                  square_t'(s), square_t'(t)};
                     exp_count++;
                  end
               end
            end
      end
      exp_wcheck = (wk >= 0) ? exp_bmap[wk] : 1'b0;
      exp_bcheck = (bk >= 0) ? exp_wmap[bk] : 1'b0;
   endtask

   task automatic run_board(input logic white, input logic with_flags);
      axi_data_t rd;
      sq_map_t map;
      for (int r = 0; r < 8; r++)
         axi_write(reg_addr_t'(REG_BOARD0 + r), board[SIDE_WIDTH*r +: SIDE_WIDTH], 0);
      axi_write(REG_SIDE, 32'(white), 0);
      axi_write(REG_CTRL, 32'h0, 0);
      axi_write(REG_CTRL, 32'h1, 0);                 // Rising new_board_valid
      wait_status(2, "moves_ready");
      build_model(white);
      axi_read(REG_MOVE_COUNT, rd);
      check_count("move_count", move_cnt_t'(rd), exp_count);
      for (int i = 0; i < exp_count; i++)
      begin
         axi_write(REG_MOVE_INDEX, 32'(i), 0);
         wait_status(3, "move_ready");
         axi_read(REG_MOVE, rd);
         check_move("move", move_t'(rd), exp_moves[i]);
      end
      read_map(REG_WATTACK_LO, map);
      check_map("white_attacking", map, exp_wmap);
      read_map(REG_BATTACK_LO, map);
      check_map("black_attacking", map, exp_bmap);
      if (with_flags)
      begin
         axi_read(REG_FLAGS, rd);
         check_word("flags", rd, {30'b0, exp_bcheck, exp_wcheck});
      end
   endtask

   task automatic reset_values();
      axi_data_t rd;
      sq_map_t map;
      axi_read(REG_CTRL, rd);
      check_word("status", rd, 32'h0000_0080);      // Only idle set
      axi_read(REG_MOVE_COUNT, rd);
      check_count("move_count", move_cnt_t'(rd), '0);
      read_map(REG_WATTACK_LO, map);
      check_map("white_attacking", map, '0);
      read_map(REG_BATTACK_LO, map);
      check_map("black_attacking", map, '0);
   endtask

   task automatic register_readback();
      axi_data_t rd;
      for (int r = 0; r < 8; r++)
         axi_write(reg_addr_t'(REG_BOARD0 + r), 32'h9e37_79b9 * (r + 1), 0);
      for (int r = 0; r < 8; r++)
      begin
         axi_read(reg_addr_t'(REG_BOARD0 + r), rd);
         check_word("board_row", rd, 32'h9e37_79b9 * (r + 1));
      end
      axi_write(REG_SIDE, 32'h1, 0);
      axi_read(REG_SIDE, rd);
      check_word("side", rd, 32'h1);
      axi_write(REG_MOVE_INDEX, 32'h2a, 0);
      axi_read(REG_MOVE_INDEX, rd);
      check_word("move_index", rd, 32'h2a);
      axi_write(REG_BOARD0, 32'h1234_5678, 5);      // Response held off
      axi_read(REG_BOARD0, rd);
      check_word("board_row", rd, 32'h1234_5678);
      axi_read(14'h40, rd);
      check_word("unmapped", rd, 32'h0);
   endtask

   task automatic lone_pieces();
      axi_data_t rd;
      board = '0;
      board[4*1 +: 4] = piece(1'b0, KIND_KNIGHT);   // b1
      board[4*4 +: 4] = piece(1'b0, KIND_KING);     // e1
      board[4*60 +: 4] = piece(1'b1, KIND_KING);    // e8
      run_board(1'b1, 1'b1);
      axi_read(REG_MOVE_COUNT, rd);
      check_word("move_count", rd, 32'd8);
   endtask

   task automatic blocking_and_captures();
      axi_data_t rd;
      board = '0;
      board[4*62 +: 4] = piece(1'b1, KIND_KNIGHT);  // g8
      board[4*60 +: 4] = piece(1'b1, KIND_KING);    // e8
      board[4*45 +: 4] = piece(1'b1, KIND_PAWN);    // f6 blocks the knight
      board[4*51 +: 4] = piece(1'b1, KIND_BISHOP);  // d7 blocks the king
      board[4*52 +: 4] = piece(1'b0, KIND_ROOK);    // e7 taken by both
      board[4*4 +: 4] = piece(1'b0, KIND_KING);
      run_board(1'b0, 1'b1);
      axi_read(REG_MOVE_COUNT, rd);
      check_word("move_count", rd, 32'd6);
   endtask

   task automatic attack_maps_and_check();
      axi_data_t rd;
      board = '0;
      board[4*19 +: 4] = piece(1'b1, KIND_KNIGHT);  // d3 hits e1
      board[4*4 +: 4] = piece(1'b0, KIND_KING);
      board[4*63 +: 4] = piece(1'b1, KIND_KING);
      run_board(1'b1, 1'b1);
      axi_read(REG_FLAGS, rd);
      check_word("flags", rd, 32'h1);
   endtask

   task automatic random_boards_and_clear();
      axi_data_t rd;
      logic white;
      for (int n = 0; n < 3; n++)
      begin
         random_board(white);
         run_board(white, 1'b0);
      end
      axi_write(REG_CTRL, 32'h2, 0);
      axi_read(REG_MOVE_COUNT, rd);
      check_count("move_count", move_cnt_t'(rd), '0);
      axi_read(REG_CTRL, rd);
      check_word("status", rd, 32'h0000_0082);
      axi_write(REG_CTRL, 32'h0, 0);
      axi_write(REG_CTRL, 32'h1, 0);
      wait_status(2, "moves_ready");
      axi_write(REG_CTRL, 32'h8000_0000, 0);
      axi_read(REG_CTRL, rd);
      check_word("status", rd, 32'h8000_0080);
      axi_write(REG_CTRL, 32'h0, 0);
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before the tests finished");
      stop_on_error();
   end

   initial
   begin
      axi_awaddr = '0;
      axi_awvalid = 1'b0;
      axi_wdata = '0;
      axi_wstrb = 4'h0;
      axi_wvalid = 1'b0;
      axi_bready = 1'b0;
      axi_araddr = '0;
      axi_arvalid = 1'b0;
      axi_rready = 1'b0;
      lfsr_state = 32'hbdc13c94;
      board = '0;
      @(posedge arst_n);
      reset_values();
      register_readback();
      lone_pieces();
      blocking_and_captures();
      attack_maps_and_check();
      random_boards_and_clear();
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
common/vchess_pkg.sv
common/am_if.sv
control/axi4lite_write.sv
control/control.sv
movegen/move_gen.sv
source/chess_ctrl_top.sv
bench/clk_gen.sv
bench/tb_chess_ctrl.sv

//--- common/am_if.sv
`timescale 1ns/1ps
`default_nettype none

interface am_if
   import vchess_pkg::*;
   ();

   logic new_board_valid;        // Level, runs on rising edge
   logic clear_moves;
   logic soft_reset;
   board_t board;
   logic white_to_move;
   move_idx_t move_index;

   logic idle;
   logic moves_ready;            // Whole list and maps valid
   logic move_ready;             // Entry at move_index valid
   move_cnt_t move_count;
   move_t move;
   sq_map_t white_attacking;
   sq_map_t black_attacking;
   logic white_in_check;
   logic black_in_check;

   modport ctrl (
      output new_board_valid, clear_moves, soft_reset, board, white_to_move, move_index,
      input idle, moves_ready, move_ready, move_count, move,
      input white_attacking, black_attacking, white_in_check, black_in_check
   );

   modport gen (
      input new_board_valid, clear_moves, soft_reset, board, white_to_move, move_index,
      output idle, moves_ready, move_ready, move_count, move,
      output white_attacking, black_attacking, white_in_check, black_in_check
   );

endinterface

`default_nettype wire

//--- common/vchess_pkg.sv
`default_nettype none

package vchess_pkg;

   localparam int BOARD_WIDTH = 256;
   localparam int SIDE_WIDTH = 32;                    // One row of eight squares
   localparam int MAX_MOVES = 64;
   localparam int COLOUR_BIT = 3;                     // Set for black

   typedef logic [3:0] piece_t;
   typedef logic [BOARD_WIDTH-1:0] board_t;
   typedef logic [5:0] square_t;
   typedef logic [12:0] move_t;                       // {capture, from, to}
   typedef logic [63:0] sq_map_t;
   typedef logic [5:0] move_idx_t;
   typedef logic [6:0] move_cnt_t;
   typedef logic [13:0] reg_addr_t;                   // Word index, byte address 15:2
   typedef logic [15:0] axi_addr_t;
   typedef logic [31:0] axi_data_t;
   typedef logic signed [2:0] step_t;

   localparam logic [2:0] KIND_EMPTY = 3'd0;
   localparam logic [2:0] KIND_PAWN = 3'd1;
   localparam logic [2:0] KIND_KNIGHT = 3'd2;
   localparam logic [2:0] KIND_BISHOP = 3'd3;
   localparam logic [2:0] KIND_ROOK = 3'd4;
   localparam logic [2:0] KIND_QUEEN = 3'd5;
   localparam logic [2:0] KIND_KING = 3'd6;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   localparam reg_addr_t REG_CTRL = 14'h00;
   localparam reg_addr_t REG_MOVE_INDEX = 14'h01;
   localparam reg_addr_t REG_SIDE = 14'h02;
   localparam reg_addr_t REG_BOARD0 = 14'h08;
   localparam reg_addr_t REG_BOARD7 = 14'h0F;
   localparam reg_addr_t REG_WATTACK_LO = 14'h80;
   localparam reg_addr_t REG_WATTACK_HI = 14'h81;
   localparam reg_addr_t REG_BATTACK_LO = 14'h82;
   localparam reg_addr_t REG_BATTACK_HI = 14'h83;
   localparam reg_addr_t REG_FLAGS = 14'h84;
   localparam reg_addr_t REG_MOVE_COUNT = 14'h87;
   localparam reg_addr_t REG_MOVE = 14'h88;

   // Row and column steps, clockwise from the first entry
   localparam step_t KNIGHT_DR [8] = '{2, 1, -1, -2, -2, -1, 1, 2};
   localparam step_t KNIGHT_DC [8] = '{1, 2, 2, 1, -1, -2, -2, -1};
   localparam step_t KING_DR [8] = '{1, 1, 0, -1, -1, -1, 0, 1};
   localparam step_t KING_DC [8] = '{0, 1, 1, 1, 0, -1, -1, -1};

   typedef enum logic [1:0] {IDLE, SCAN, FLAGS, DONE} gen_state_t;

endpackage

`default_nettype wire

//--- control/axi4lite_write.sv
`timescale 1ns/1ps
`default_nettype none

module axi4lite_write
   import vchess_pkg::*;
   (
   input  logic clk,
   input  logic arst_n,

   input  axi_addr_t axi_awaddr,
   input  logic axi_awvalid,
   output logic axi_awready,
   input  axi_data_t axi_wdata,
   input  logic [3:0] axi_wstrb,
   input  logic axi_wvalid,
   output logic axi_wready,
   output logic [1:0] axi_bresp,
   output logic axi_bvalid,
   input  logic axi_bready,

   output axi_addr_t addr,
   output axi_data_t data,
   output logic valid
   );

   logic aw_full;
   logic w_full;

   assign axi_awready = !aw_full;
   assign axi_wready = !w_full;
   assign axi_bresp = RESP_OKAY;

   always_ff @(posedge clk or negedge arst_n)
      if (!arst_n)
      begin
         aw_full <= 1'b0;
         w_full <= 1'b0;
         valid <= 1'b0;
         axi_bvalid <= 1'b0;
      end
      else
      begin
         if (axi_awvalid && !aw_full)
            aw_full <= 1'b1;
         if (axi_wvalid && !w_full)
            w_full <= 1'b1;
         valid <= aw_full && w_full && !axi_bvalid;    // Once per transfer
         if (aw_full && w_full && !axi_bvalid)
            axi_bvalid <= 1'b1;
         if (axi_bvalid && axi_bready)
         begin
            axi_bvalid <= 1'b0;
            aw_full <= 1'b0;
            w_full <= 1'b0;
         end
      end

   always_ff @(posedge clk)
   begin
      if (axi_awvalid && !aw_full)
         addr <= axi_awaddr;
      if (axi_wvalid && !w_full)
         for (int i = 0; i < 4; i++)
            data[8*i +: 8] <= axi_wstrb[i] ? axi_wdata[8*i +: 8] : 8'h00;  // Unstrobed lanes zero
   end

   a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
      axi_bvalid && !axi_bready |=> axi_bvalid)
      else $error("bvalid dropped before bready");

endmodule

`default_nettype wire

//--- control/control.sv
`timescale 1ns/1ps
`default_nettype none

module control
   import vchess_pkg::*;
   (
   input  logic clk,
   input  logic arst_n,

   input  axi_addr_t axi_awaddr,
   input  logic axi_awvalid,
   output logic axi_awready,
   input  axi_data_t axi_wdata,
   input  logic [3:0] axi_wstrb,
   input  logic axi_wvalid,
   output logic axi_wready,
   output logic [1:0] axi_bresp,
   output logic axi_bvalid,
   input  logic axi_bready,
   input  axi_addr_t axi_araddr,
   input  logic axi_arvalid,
   output logic axi_arready,
   output axi_data_t axi_rdata,
   output logic [1:0] axi_rresp,
   output logic axi_rvalid,
   input  logic axi_rready,

   am_if.ctrl am
   );

   axi_addr_t wr_addr;
   axi_data_t wr_data;
   logic wr_valid;
   reg_addr_t wr_reg;
   reg_addr_t rd_reg;
   axi_data_t rd_word;

   assign axi_arready = 1'b1;                         // Reads never stall
   assign axi_rresp = RESP_OKAY;
   assign wr_reg = wr_addr[15:2];
   assign rd_reg = axi_araddr[15:2];

   axi4lite_write axi4lite_write_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .axi_awaddr  (axi_awaddr),
      .axi_awvalid (axi_awvalid),
      .axi_awready (axi_awready),
      .axi_wdata   (axi_wdata),
      .axi_wstrb   (axi_wstrb),
      .axi_wvalid  (axi_wvalid),
      .axi_wready  (axi_wready),
      .axi_bresp   (axi_bresp),
      .axi_bvalid  (axi_bvalid),
      .axi_bready  (axi_bready),
      .addr        (wr_addr),
      .data        (wr_data),
      .valid       (wr_valid)
   );

   always_ff @(posedge clk or negedge arst_n)
      if (!arst_n)
      begin
         am.new_board_valid <= 1'b0;
         am.clear_moves <= 1'b0;
         am.soft_reset <= 1'b0;
         am.move_index <= '0;
         am.white_to_move <= 1'b0;
         am.board <= '0;
      end
      else if (wr_valid)
         case (wr_reg) inside
            REG_CTRL:
            begin
               am.new_board_valid <= wr_data[0];
               am.clear_moves <= wr_data[1];
               am.soft_reset <= wr_data[31];
            end
            REG_MOVE_INDEX: am.move_index <= wr_data[5:0];
            REG_SIDE: am.white_to_move <= wr_data[0];
            [REG_BOARD0:REG_BOARD7]: am.board[SIDE_WIDTH*wr_reg[2:0] +: SIDE_WIDTH] <= wr_data;
            default:
            begin
            end
         endcase

   always_comb
   begin
      rd_word = '0;
      case (rd_reg) inside
         REG_CTRL:
         begin
            rd_word[0] = am.new_board_valid;
            rd_word[1] = am.clear_moves;
            rd_word[2] = am.moves_ready;
            rd_word[3] = am.move_ready;
            rd_word[7] = am.idle;
            rd_word[31] = am.soft_reset;
         end
         REG_MOVE_INDEX: rd_word = 32'(am.move_index);
         REG_SIDE: rd_word = 32'(am.white_to_move);
         [REG_BOARD0:REG_BOARD7]: rd_word = am.board[SIDE_WIDTH*rd_reg[2:0] +: SIDE_WIDTH];
         REG_WATTACK_LO: rd_word = am.white_attacking[31:0];
         REG_WATTACK_HI: rd_word = am.white_attacking[63:32];
         REG_BATTACK_LO: rd_word = am.black_attacking[31:0];
         REG_BATTACK_HI: rd_word = am.black_attacking[63:32];
         REG_FLAGS: rd_word = {30'b0, am.black_in_check, am.white_in_check};
         REG_MOVE_COUNT: rd_word = 32'(am.move_count);
         REG_MOVE: rd_word = 32'(am.move);            // Capture, from, to
         default: rd_word = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
      if (!arst_n)
      begin
         axi_rvalid <= 1'b0;
         axi_rdata <= '0;
      end
      else
      begin
         if (axi_rready)
            axi_rvalid <= 1'b0;
         if (axi_arvalid)
         begin
            axi_rdata <= rd_word;
            axi_rvalid <= 1'b1;
         end
      end

   // One read outstanding at a time
   a_one_read: assert property (@(posedge clk) disable iff (!arst_n)
      axi_rvalid && !axi_rready |-> !axi_arvalid)
      else $error("read issued while previous data not taken");

endmodule

`default_nettype wire

//--- movegen/move_gen.sv
`timescale 1ns/1ps
`default_nettype none

module move_gen
   import vchess_pkg::*;
   (
   input  logic clk,
   input  logic arst_n,
   am_if.gen am
   );

   gen_state_t state;
   square_t sq;
   square_t tsq;
   square_t wk_sq;
   square_t bk_sq;
   logic [2:0] dir;
   logic nbv_q;
   logic start;
   logic step_en;
   piece_t p;
   piece_t tp;
   step_t dr;
   step_t dc;
   logic signed [4:0] t_row;
   logic signed [4:0] t_col;
   logic on_board;
   logic is_mover;
   logic own_side;
   logic tgt_empty;
   logic tgt_enemy;
   logic attack;
   logic append;
   logic king_here;
   logic wk_found;
   logic bk_found;
   move_idx_t idx_q;
   move_t move_list [MAX_MOVES];

   assign start = am.new_board_valid && !nbv_q;      // Rising level
   assign step_en = (state == SCAN) && !am.clear_moves && !am.soft_reset && !start;

   assign p = am.board[4*sq +: 4];
   assign is_mover = (p[2:0] == KIND_KNIGHT) || (p[2:0] == KIND_KING);
   assign dr = (p[2:0] == KIND_KNIGHT) ? KNIGHT_DR[dir] : KING_DR[dir];
   assign dc = (p[2:0] == KIND_KNIGHT) ? KNIGHT_DC[dir] : KING_DC[dir];
   assign t_row = $signed({2'b00, sq[5:3]}) + 5'(dr);
   assign t_col = $signed({2'b00, sq[2:0]}) + 5'(dc);
   assign on_board = (t_row[4:3] == 2'b00) && (t_col[4:3] == 2'b00);
   assign tsq = {t_row[2:0], t_col[2:0]};

   assign tp = am.board[4*tsq +: 4];
   assign tgt_empty = (tp[2:0] == KIND_EMPTY);
   assign tgt_enemy = !tgt_empty && (tp[COLOUR_BIT] != p[COLOUR_BIT]);
   assign own_side = (p[COLOUR_BIT] == !am.white_to_move);

   assign attack = step_en && is_mover && on_board;
   assign append = attack && own_side && (tgt_empty || tgt_enemy) &&
                   (am.move_count < MAX_MOVES);
   assign king_here = step_en && (p[2:0] == KIND_KING) && (dir == 3'd0);

   assign am.idle = (state == IDLE);
   assign am.moves_ready = (state == DONE);
   assign am.move_ready = (state == DONE) && (idx_q == am.move_index);

   always_ff @(posedge clk or negedge arst_n)
      if (!arst_n)
      begin
         state <= IDLE;
         sq <= '0;
         dir <= '0;
         nbv_q <= 1'b0;
         am.move_count <= '0;
         am.white_attacking <= '0;
         am.black_attacking <= '0;
         am.white_in_check <= 1'b0;
         am.black_in_check <= 1'b0;
         wk_found <= 1'b0;
         bk_found <= 1'b0;
      end
      else
      begin
         nbv_q <= am.new_board_valid;
         if (am.clear_moves || am.soft_reset)
         begin
            state <= IDLE;
            am.move_count <= '0;
         end
         else if (start)
         begin
            state <= SCAN;
            sq <= '0;
            dir <= '0;
            am.move_count <= '0;
            am.white_attacking <= '0;
            am.black_attacking <= '0;
            am.white_in_check <= 1'b0;
            am.black_in_check <= 1'b0;
            wk_found <= 1'b0;
            bk_found <= 1'b0;
         end
         else
            case (state)
               SCAN:
               begin
                  if (attack && p[COLOUR_BIT])
                     am.black_attacking[tsq] <= 1'b1;
                  if (attack && !p[COLOUR_BIT])
                     am.white_attacking[tsq] <= 1'b1;
                  if (append)
                     am.move_count <= am.move_count + 7'd1;
                  if (king_here && p[COLOUR_BIT])
                     bk_found <= 1'b1;
                  if (king_here && !p[COLOUR_BIT])
                     wk_found <= 1'b1;
                  dir <= dir + 3'd1;
                  if (dir == 3'd7)
                  begin
                     sq <= sq + 6'd1;
                     if (sq == 6'd63)
                        state <= FLAGS;
                  end
               end
               FLAGS:
               begin
                  am.white_in_check <= wk_found && am.black_attacking[wk_sq];
                  am.black_in_check <= bk_found && am.white_attacking[bk_sq];
                  state <= DONE;
               end
               default:
               begin
               end
            endcase
      end

   always_ff @(posedge clk)
   begin
      if (append)
         move_list[am.move_count[5:0]] <= {tgt_enemy, sq, tsq};
      if (king_here && p[COLOUR_BIT])
         bk_sq <= sq;
      if (king_here && !p[COLOUR_BIT])
         wk_sq <= sq;
      am.move <= move_list[am.move_index];           // Registered read
      idx_q <= am.move_index;
   end

   // Board and side are read directly while scanning
   a_board_stable: assert property (@(posedge clk) disable iff (!arst_n)
      state == SCAN |-> $stable(am.board) && $stable(am.white_to_move))
      else $error("board or side changed during a scan");

endmodule

`default_nettype wire

//--- source/chess_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module chess_ctrl_top
   import vchess_pkg::*;
   (
   input  logic clk,
   input  logic arst_n,

   input  axi_addr_t axi_awaddr,
   input  logic axi_awvalid,
   output logic axi_awready,
   input  axi_data_t axi_wdata,
   input  logic [3:0] axi_wstrb,
   input  logic axi_wvalid,
   output logic axi_wready,
   output logic [1:0] axi_bresp,
   output logic axi_bvalid,
   input  logic axi_bready,
   input  axi_addr_t axi_araddr,
   input  logic axi_arvalid,
   output logic axi_arready,
   output axi_data_t axi_rdata,
   output logic [1:0] axi_rresp,
   output logic axi_rvalid,
   input  logic axi_rready
   );

   am_if am_i ();

   control control_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .axi_awaddr  (axi_awaddr),
      .axi_awvalid (axi_awvalid),
      .axi_awready (axi_awready),
      .axi_wdata   (axi_wdata),
      .axi_wstrb   (axi_wstrb),
      .axi_wvalid  (axi_wvalid),
      .axi_wready  (axi_wready),
      .axi_bresp   (axi_bresp),
      .axi_bvalid  (axi_bvalid),
      .axi_bready  (axi_bready),
      .axi_araddr  (axi_araddr),
      .axi_arvalid (axi_arvalid),
      .axi_arready (axi_arready),
      .axi_rdata   (axi_rdata),
      .axi_rresp   (axi_rresp),
      .axi_rvalid  (axi_rvalid),
      .axi_rready  (axi_rready),
      .am          (am_i.ctrl)
   );

   move_gen move_gen_i (
      .clk    (clk),
      .arst_n (arst_n),
      .am     (am_i.gen)
   );

endmodule

`default_nettype wire
